// ==== files.f ====
source/core_pkg.sv
source/mem_pkg.sv
source/ex_mem_reg.sv
source/mem_access.sv
source/apb_data_ram.sv
source/mem_wb_reg.sv
source/lsu_backend_top.sv
testbench/tb_clock_gen.sv
testbench/backend_props.sv
testbench/backend_tb.sv

// ==== Bender.yml ====
package:
  name: lsu_backend

sources:
  # packages come first, the stages use their types
  - files:
      - source/core_pkg.sv
      - source/mem_pkg.sv
      - source/ex_mem_reg.sv
      - source/mem_access.sv
      - source/apb_data_ram.sv
      - source/mem_wb_reg.sv
      - source/lsu_backend_top.sv

  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/backend_props.sv
      - testbench/backend_tb.sv

// ==== testbench/backend_tb.sv ====
/*
 * backend_tb
 * Directed tests for the pipeline back end. Plays the execute stage, keeps
 * an in-order retirement model plus a byte memory model, checks write-back.
 */
module backend_tb;

    localparam int reset_cycles = 16;
    localparam int total_insts  = 20 + 8 + 30 + 1 + 40;
    localparam int drain_limit  = 64;

    typedef struct {
        core_pkg::pc_t        pc;
        core_pkg::inst_type_t inst_type;
        logic                 rd_ena;
        core_pkg::reg_addr_t  rd_addr;
        core_pkg::xlen_t      rd_data;
        bit                   chk_lat;
        int unsigned          acc_cycle;
    } retire_t;

    logic                 clk;
    logic                 arst_n;
    core_pkg::pc_t        ex_pc;
    core_pkg::inst_type_t ex_inst_type;
    logic                 ex_rd_ena;
    core_pkg::xlen_t      ex_rd_data;
    core_pkg::reg_addr_t  ex_rd_addr;
    mem_pkg::ls_sel_t     ex_ls_sel;
    mem_pkg::data_addr_t  ex_ls_addr;
    logic                 ex_stall_req;
    core_pkg::pc_t        wb_pc;
    core_pkg::inst_type_t wb_inst_type;
    logic                 wb_rd_ena;
    core_pkg::reg_addr_t  wb_rd_addr;
    core_pkg::xlen_t      wb_rd_data;
    core_pkg::stall_t     stall_ctrl;

    retire_t              exp_q[$];
    logic [7:0]           mem_model [longint unsigned];
    logic [31:0]          lfsr_state = 32'h809f9787;
    core_pkg::pc_t        next_pc = 64'h1000;
    int unsigned          cycle = 0;
    int                   errors = 0;
    int                   checks = 0;

    tb_clock_gen u_clock_gen (.clk(clk));

    lsu_backend_top uut (.*);

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'ha300_0000) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic int size_bytes(input mem_pkg::ls_sel_t sel);
        case (sel[1:0])
            2'd0:    return 1;
            2'd1:    return 2;
            2'd2:    return 4;
            default: return 8;
        endcase
    endfunction

    function automatic logic [7:0] model_byte(input longint unsigned a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return 8'h00;
    endfunction

    function automatic core_pkg::xlen_t load_expect(input mem_pkg::data_addr_t addr,
                                                    input mem_pkg::ls_sel_t sel);
        int          n;
        logic [63:0] v;
        n = size_bytes(sel);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model_byte(addr + i);
        end
        // codes below ls_dword sign-extend from the top loaded bit
        if (sel < mem_pkg::ls_dword && v[8*n-1]) begin
            v = v | ~((64'd1 << (8*n)) - 64'd1);
        end
        return v;
    endfunction

    // naturally aligned address inside the dword selected by idx
    function automatic mem_pkg::data_addr_t aligned_addr(input mem_pkg::ls_sel_t sel,
                                                         input logic [7:0] idx);
        logic [2:0] off;
        off = 3'(rand_bits(3)) & 3'(8 - size_bytes(sel));
        return mem_pkg::data_addr_t'({idx, off});
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp, input core_pkg::pc_t pc);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h (pc %h)", name, got, exp, pc);
            errors++;
        end
    endtask

    task automatic drive_idle();
        ex_pc        <= '0;
        ex_inst_type <= core_pkg::inst_none;
        ex_rd_ena    <= 1'b0;
        ex_rd_data   <= '0;
        ex_rd_addr   <= '0;
        ex_ls_sel    <= '0;
        ex_ls_addr   <= '0;
    endtask

    // presents one instruction and returns just after the edge that takes it
    task automatic issue(input core_pkg::inst_type_t it, input logic rd_ena,
                         input core_pkg::xlen_t data, input mem_pkg::ls_sel_t sel,
                         input mem_pkg::data_addr_t addr, input bit chk_lat);
        retire_t             e;
        core_pkg::reg_addr_t rd;
        rd = core_pkg::reg_addr_t'(rand_bits(5));
        next_pc = next_pc + 64'd4;
        ex_pc        <= next_pc;
        ex_inst_type <= it;
        ex_rd_ena    <= rd_ena;
        ex_rd_data   <= data;
        ex_rd_addr   <= rd;
        ex_ls_sel    <= sel;
        ex_ls_addr   <= addr;
        @(negedge clk);
        while (stall_ctrl[core_pkg::stall_ex]) begin
            @(posedge clk);
            @(negedge clk);
        end
        e.pc        = next_pc;
        e.inst_type = it;
        e.rd_ena    = rd_ena;
        e.rd_addr   = rd;
        e.rd_data   = data;
        if (it == core_pkg::inst_load) begin
            e.rd_data = load_expect(addr, sel);
        end
        if (it == core_pkg::inst_store) begin
            for (int i = 0; i < size_bytes(sel); i++) begin
                mem_model[addr + i] = data[8*i +: 8];
            end
        end
        e.chk_lat   = chk_lat;
        e.acc_cycle = cycle + 1;
        exp_q.push_back(e);
        @(posedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("pipeline did not drain, %0d instructions outstanding after %0d cycles",
                     exp_q.size(), waited);
            errors++;
            exp_q.delete();
        end
        @(posedge clk);
    endtask

    // the retirement monitor compares every non-bubble write-back with the model
    always @(negedge clk) begin
        retire_t e;
        if (arst_n && wb_pc != '0) begin
            if (exp_q.size() == 0) begin
                $display("unexpected retirement of pc %h with nothing outstanding", wb_pc);
                errors++;
            end else begin
                e = exp_q.pop_front();
                compare_value("wb_pc", wb_pc, e.pc, e.pc);
                compare_value("wb_inst_type", wb_inst_type, e.inst_type, e.pc);
                compare_value("wb_rd_ena", wb_rd_ena, e.rd_ena, e.pc);
                compare_value("wb_rd_addr", wb_rd_addr, e.rd_addr, e.pc);
                compare_value("wb_rd_data", wb_rd_data, e.rd_data, e.pc);
                if (e.chk_lat && cycle != e.acc_cycle + 1) begin
                    $display("pc %h retired %0d cycles after issue instead of 1",
                             e.pc, cycle - e.acc_cycle);
                    errors++;
                end
            end
        end else if (arst_n && wb_rd_ena) begin
            $display("ERROR wb_rd_ena: got %h expected %h in a bubble", wb_rd_ena, 1'b0);
            errors++;
        end
    end

    task automatic reset_values();
        @(negedge clk);
        compare_value("stall_ctrl", stall_ctrl, '0, '0);
        compare_value("wb_rd_ena", wb_rd_ena, '0, '0);
        compare_value("wb_pc", wb_pc, '0, '0);
        @(posedge clk);
    endtask

    task automatic alu_pass_through();
        logic            ena;
        core_pkg::xlen_t data;
        repeat (20) begin
            ena  = (rand_bits(1) != 0);
            data = rand_bits(64);
            issue(core_pkg::inst_alu, ena, data, mem_pkg::ls_sel_t'(rand_bits(3)), '0, 1'b1);
        end
        drive_idle();
        wait_drain();
    endtask

    task automatic store_then_load();
        mem_pkg::ls_sel_t    sel;
        mem_pkg::data_addr_t addr;
        for (int s = 0; s < 4; s++) begin
            sel  = mem_pkg::ls_sel_t'(s);
            addr = aligned_addr(sel, 8'(rand_bits(8)));
            issue(core_pkg::inst_store, 1'b0, rand_bits(64), sel, addr, 1'b0);
            issue(core_pkg::inst_load, 1'b1, '0, mem_pkg::ls_dword, {addr[63:3], 3'b000}, 1'b0);
        end
        drive_idle();
        wait_drain();
    endtask

    task automatic subword_loads();
        mem_pkg::data_addr_t base;
        mem_pkg::ls_sel_t    sel;
        core_pkg::xlen_t     data;
        base = aligned_addr(mem_pkg::ls_dword, 8'(rand_bits(8)));
        data = rand_bits(64);
        // both signs appear among the words, halves and bytes
        data[63] = 1'b1;
        data[31] = 1'b0;
        data[15] = 1'b1;
        data[7]  = 1'b0;
        issue(core_pkg::inst_store, 1'b0, data, mem_pkg::ls_dword, base, 1'b0);
        for (int s = 0; s < 7; s++) begin
            sel = mem_pkg::ls_sel_t'(s);
            for (int off = 0; off < 8; off += size_bytes(sel)) begin
                issue(core_pkg::inst_load, 1'b1, '0, sel, base + off, 1'b0);
            end
        end
        drive_idle();
        wait_drain();
    endtask

    task automatic ex_stall_bubbles();
        core_pkg::stall_t stall_exp;
        // an execute stall holds every stage up to execute and lets memory run
        stall_exp = '1;
        stall_exp[core_pkg::stall_mem] = 1'b0;
        ex_stall_req <= 1'b1;
        fork
            begin
                repeat (6) begin
                    @(negedge clk);
                    compare_value("stall_ctrl", stall_ctrl, stall_exp, '0);
                    compare_value("wb_pc", wb_pc, '0, '0);
                    compare_value("wb_rd_ena", wb_rd_ena, '0, '0);
                end
                @(posedge clk);
                ex_stall_req <= 1'b0;
            end
            begin
                issue(core_pkg::inst_alu, 1'b1, rand_bits(64), '0, '0, 1'b0);
                drive_idle();
            end
        join
        wait_drain();
    endtask

    task automatic mixed_stream();
        logic [1:0]          kind;
        mem_pkg::ls_sel_t    sel;
        mem_pkg::data_addr_t addr;
        repeat (40) begin
            kind = 2'(rand_bits(2));
            sel  = mem_pkg::ls_sel_t'(rand_bits(3));
            if (sel == 3'd7) begin
                sel = mem_pkg::ls_dword;
            end
            // a pool of eight dwords so loads often hit earlier stores
            addr = aligned_addr(sel, 8'(8'h80 + rand_bits(3)));
            case (kind)
                2'd2:    issue(core_pkg::inst_load, 1'b1, '0, sel, addr, 1'b0);
                2'd3:    issue(core_pkg::inst_store, 1'b0, rand_bits(64),
                               mem_pkg::ls_sel_t'(sel[1:0]), addr, 1'b0);
                default: issue(core_pkg::inst_alu, 1'b1, rand_bits(64), sel, addr, 1'b0);
            endcase
        end
        drive_idle();
        wait_drain();
    endtask

    initial begin
        repeat (reset_cycles + total_insts * 16) @(posedge clk);
        $display("timeout: watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        arst_n       <= 1'b0;
        ex_stall_req <= 1'b0;
        drive_idle();
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
        reset_values();
        alu_pass_through();
        store_then_load();
        subword_loads();
        ex_stall_bubbles();
        mixed_stream();
        errors += uut.u_mem_access.u_backend_props.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/backend_props.sv ====
/*
 * backend_props
 * APB handshake and stall-vector assertions for the memory stage.
 */
module backend_props (
    input logic               clk,
    input logic               arst_n,
    input logic               psel,
    input logic               penable,
    input logic               pwrite,
    input logic               pready,
    input mem_pkg::apb_addr_t paddr,
    input mem_pkg::apb_data_t pwdata,
    input core_pkg::stall_t   stall_ctrl
);

    int unsigned fail_count = 0;

    // the access phase follows exactly one setup cycle
    setup_then_access: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(psel) |=> penable
    ) else begin
        $error("penable did not follow the setup cycle");
        fail_count++;
    end

    access_after_setup: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(penable) |-> $past(psel && !penable)
    ) else begin
        $error("penable rose without a preceding setup cycle");
        fail_count++;
    end

    access_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (penable && !pready) |=> ($stable(paddr) && $stable(pwrite) && $stable(pwdata))
    ) else begin
        $error("master signals changed during a waited access phase");
        fail_count++;
    end

    stall_while_selected: assert property (
        @(posedge clk) disable iff (!arst_n) psel |-> (&stall_ctrl)
    ) else begin
        $error("stall vector not fully set during an APB transfer");
        fail_count++;
    end

endmodule

bind mem_access backend_props u_backend_props (
    .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pready(pready), .paddr(paddr), .pwdata(pwdata), .stall_ctrl(stall_ctrl)
);

// ==== testbench/tb_clock_gen.sv ====
/*
 * tb_clock_gen
 * Free-running testbench clock with a period of 4 time units.
 */
module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

// ==== source/lsu_backend_top.sv ====
/*
 * lsu_backend_top
 * Back half of the RV64 pipeline: EX/MEM register, memory stage with its
 * APB data RAM, and the MEM/WB register feeding write-back.
 */
module lsu_backend_top #(
    parameter int unsigned wait_states = 1
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  core_pkg::pc_t        ex_pc,
    input  core_pkg::inst_type_t ex_inst_type,
    input  logic                 ex_rd_ena,
    input  core_pkg::xlen_t      ex_rd_data,
    input  core_pkg::reg_addr_t  ex_rd_addr,
    input  mem_pkg::ls_sel_t     ex_ls_sel,
    input  mem_pkg::data_addr_t  ex_ls_addr,
    input  logic                 ex_stall_req,
    output core_pkg::pc_t        wb_pc,
    output core_pkg::inst_type_t wb_inst_type,
    output logic                 wb_rd_ena,
    output core_pkg::reg_addr_t  wb_rd_addr,
    output core_pkg::xlen_t      wb_rd_data,
    output core_pkg::stall_t     stall_ctrl
);

    core_pkg::pc_t        mem_pc;
    core_pkg::inst_type_t mem_inst_type;
    logic                 mem_rd_ena;
    core_pkg::xlen_t      mem_rd_data;
    core_pkg::reg_addr_t  mem_rd_addr;
    mem_pkg::ls_sel_t     mem_ls_sel;
    mem_pkg::data_addr_t  mem_ls_addr;

    core_pkg::pc_t        res_pc;
    core_pkg::inst_type_t res_inst_type;
    logic                 res_rd_ena;
    core_pkg::xlen_t      res_rd_data;
    core_pkg::reg_addr_t  res_rd_addr;

    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic                 pready;
    mem_pkg::apb_addr_t   paddr;
    mem_pkg::apb_data_t   pwdata;
    mem_pkg::apb_data_t   prdata;
    mem_pkg::apb_strb_t   pstrb;

    ex_mem_reg u_ex_mem_reg (
        .clk(clk), .arst_n(arst_n), .stall_ctrl(stall_ctrl),
        .ex_pc(ex_pc), .ex_inst_type(ex_inst_type), .ex_rd_ena(ex_rd_ena),
        .ex_rd_data(ex_rd_data), .ex_rd_addr(ex_rd_addr),
        .ex_ls_sel(ex_ls_sel), .ex_ls_addr(ex_ls_addr),
        .mem_pc(mem_pc), .mem_inst_type(mem_inst_type), .mem_rd_ena(mem_rd_ena),
        .mem_rd_data(mem_rd_data), .mem_rd_addr(mem_rd_addr),
        .mem_ls_sel(mem_ls_sel), .mem_ls_addr(mem_ls_addr)
    );

    mem_access u_mem_access (
        .clk(clk), .arst_n(arst_n), .ex_stall_req(ex_stall_req),
        .mem_pc(mem_pc), .mem_inst_type(mem_inst_type), .mem_rd_ena(mem_rd_ena),
        .mem_rd_data(mem_rd_data), .mem_rd_addr(mem_rd_addr),
        .mem_ls_sel(mem_ls_sel), .mem_ls_addr(mem_ls_addr),
        .prdata(prdata), .pready(pready), .stall_ctrl(stall_ctrl),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .res_pc(res_pc), .res_inst_type(res_inst_type), .res_rd_ena(res_rd_ena),
        .res_rd_data(res_rd_data), .res_rd_addr(res_rd_addr)
    );

    apb_data_ram #(
        .wait_states(wait_states)
    ) u_apb_data_ram (
        .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .prdata(prdata), .pready(pready)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk(clk), .arst_n(arst_n), .stall_ctrl(stall_ctrl),
        .res_pc(res_pc), .res_inst_type(res_inst_type), .res_rd_ena(res_rd_ena),
        .res_rd_data(res_rd_data), .res_rd_addr(res_rd_addr),
        .wb_pc(wb_pc), .wb_inst_type(wb_inst_type), .wb_rd_ena(wb_rd_ena),
        .wb_rd_data(wb_rd_data), .wb_rd_addr(wb_rd_addr)
    );

endmodule

// ==== source/mem_wb_reg.sv ====
/*
 * mem_wb_reg
 * Pipeline register into write-back. Takes a bubble while the memory
 * stage is stalled so a waiting load or store retires once.
 */
module mem_wb_reg (
    input  logic                 clk,
    input  logic                 arst_n,
    input  core_pkg::stall_t     stall_ctrl,
    input  core_pkg::pc_t        res_pc,
    input  core_pkg::inst_type_t res_inst_type,
    input  logic                 res_rd_ena,
    input  core_pkg::xlen_t      res_rd_data,
    input  core_pkg::reg_addr_t  res_rd_addr,
    output core_pkg::pc_t        wb_pc,
    output core_pkg::inst_type_t wb_inst_type,
    output logic                 wb_rd_ena,
    output core_pkg::xlen_t      wb_rd_data,
    output core_pkg::reg_addr_t  wb_rd_addr
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_pc        <= '0;
            wb_inst_type <= core_pkg::inst_none;
            wb_rd_ena    <= 1'b0;
            wb_rd_data   <= '0;
            wb_rd_addr   <= '0;
        end else if (stall_ctrl[core_pkg::stall_mem]) begin
            // an instruction still waiting on memory leaves a bubble behind it
            wb_pc        <= '0;
            wb_inst_type <= core_pkg::inst_none;
            wb_rd_ena    <= 1'b0;
            wb_rd_data   <= '0;
            wb_rd_addr   <= '0;
        end else begin
            wb_pc        <= res_pc;
            wb_inst_type <= res_inst_type;
            wb_rd_ena    <= res_rd_ena;
            wb_rd_data   <= res_rd_data;
            wb_rd_addr   <= res_rd_addr;
        end
    end

endmodule

// ==== source/apb_data_ram.sv ====
/*
 * apb_data_ram
 * Dword-wide data memory behind an APB slave port. Byte strobes select
 * the written lanes; pready is held low for wait_states access cycles.
 */
module apb_data_ram #(
    parameter int unsigned wait_states = 1
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  mem_pkg::apb_addr_t paddr,
    input  mem_pkg::apb_data_t pwdata,
    input  mem_pkg::apb_strb_t pstrb,
    output mem_pkg::apb_data_t prdata,
    output logic               pready
);

    localparam int cnt_bits = $clog2(wait_states + 2);

    mem_pkg::apb_data_t                 mem [mem_pkg::ram_depth_words];
    logic [mem_pkg::ram_index_bits-1:0] word_idx;
    logic [cnt_bits-1:0]                wait_cnt;
    logic                               access_phase;

    initial begin
        for (int i = 0; i < mem_pkg::ram_depth_words; i++) begin
            mem[i] = '0;
        end
    end

    assign word_idx     = paddr[mem_pkg::ram_index_bits+2:3];
    assign access_phase = psel && penable;
    assign pready       = access_phase && (wait_cnt == cnt_bits'(wait_states));
    assign prdata       = mem[word_idx];

    // counts the wait cycles of the current access phase, cleared outside it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (access_phase && !pready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (access_phase && pready && pwrite) begin
            for (int b = 0; b < $bits(pstrb); b++) begin
                if (pstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== source/mem_access.sv ====
/*
 * mem_access
 * Memory stage. Runs one APB transfer per load or store, builds the
 * pipeline stall vector and extends load data by the access selector.
 */
module mem_access (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 ex_stall_req,
    input  core_pkg::pc_t        mem_pc,
    input  core_pkg::inst_type_t mem_inst_type,
    input  logic                 mem_rd_ena,
    input  core_pkg::xlen_t      mem_rd_data,
    input  core_pkg::reg_addr_t  mem_rd_addr,
    input  mem_pkg::ls_sel_t     mem_ls_sel,
    input  mem_pkg::data_addr_t  mem_ls_addr,
    input  mem_pkg::apb_data_t   prdata,
    input  logic                 pready,
    output core_pkg::stall_t     stall_ctrl,
    output logic                 psel,
    output logic                 penable,
    output logic                 pwrite,
    output mem_pkg::apb_addr_t   paddr,
    output mem_pkg::apb_data_t   pwdata,
    output mem_pkg::apb_strb_t   pstrb,
    output core_pkg::pc_t        res_pc,
    output core_pkg::inst_type_t res_inst_type,
    output logic                 res_rd_ena,
    output core_pkg::xlen_t      res_rd_data,
    output core_pkg::reg_addr_t  res_rd_addr
);

    typedef enum logic [1:0] {
        state_idle,
        state_setup,
        state_access,
        state_done
    } state_t;

    state_t             state;
    state_t             state_next;
    logic               is_load;
    logic               is_store;
    logic               mem_busy;
    logic [2:0]         byte_off;
    mem_pkg::apb_strb_t size_mask;
    mem_pkg::apb_data_t load_data;
    core_pkg::xlen_t    lane_data;
    core_pkg::xlen_t    load_ext;

    assign is_load  = (mem_inst_type == core_pkg::inst_load);
    assign is_store = (mem_inst_type == core_pkg::inst_store);
    assign byte_off = mem_ls_addr[2:0];

    // busy until the DONE cycle, which lets both pipeline registers advance
    assign mem_busy = (is_load || is_store) && (state != state_done);

    always_comb begin
        state_next = state;
        case (state)
            state_idle:   if (is_load || is_store) state_next = state_setup;
            state_setup:  state_next = state_access;
            state_access: if (pready) state_next = state_done;
            state_done:   state_next = state_idle;
            default:      state_next = state_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= state_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == state_access && pready) begin
            load_data <= prdata;
        end
    end

    always_comb begin
        stall_ctrl = '0;
        if (mem_busy) begin
            stall_ctrl = '1;
        end else if (ex_stall_req) begin
            stall_ctrl[core_pkg::stall_pc] = 1'b1;
            stall_ctrl[core_pkg::stall_if] = 1'b1;
            stall_ctrl[core_pkg::stall_id] = 1'b1;
            stall_ctrl[core_pkg::stall_ex] = 1'b1;
        end
    end

    always_comb begin
        case (mem_ls_sel)
            mem_pkg::ls_byte, mem_pkg::ls_byte_u: size_mask = 8'h01;
            mem_pkg::ls_half, mem_pkg::ls_half_u: size_mask = 8'h03;
            mem_pkg::ls_word, mem_pkg::ls_word_u: size_mask = 8'h0f;
            default:                              size_mask = 8'hff;
        endcase
    end

    // master signals come from the held EX/MEM entry, so they stay stable in ACCESS
    assign psel    = (state == state_setup) || (state == state_access);
    assign penable = (state == state_access);
    assign pwrite  = is_store;
    assign paddr   = {mem_ls_addr[31:3], 3'b000};
    assign pwdata  = mem_rd_data << {byte_off, 3'b000};
    assign pstrb   = is_store ? mem_pkg::apb_strb_t'(size_mask << byte_off) : '0;

    assign lane_data = load_data >> {byte_off, 3'b000};

    always_comb begin
        case (mem_ls_sel)
            mem_pkg::ls_byte:   load_ext = {{56{lane_data[7]}}, lane_data[7:0]};
            mem_pkg::ls_half:   load_ext = {{48{lane_data[15]}}, lane_data[15:0]};
            mem_pkg::ls_word:   load_ext = {{32{lane_data[31]}}, lane_data[31:0]};
            mem_pkg::ls_dword:  load_ext = lane_data;
            mem_pkg::ls_byte_u: load_ext = {56'd0, lane_data[7:0]};
            mem_pkg::ls_half_u: load_ext = {48'd0, lane_data[15:0]};
            mem_pkg::ls_word_u: load_ext = {32'd0, lane_data[31:0]};
            default:            load_ext = lane_data;
        endcase
    end

    assign res_pc        = mem_pc;
    assign res_inst_type = mem_inst_type;
    assign res_rd_ena    = mem_rd_ena;
    assign res_rd_addr   = mem_rd_addr;
    assign res_rd_data   = (state == state_done && is_load) ? load_ext : mem_rd_data;

endmodule

// ==== source/ex_mem_reg.sv ====
/*
 * ex_mem_reg
 * Pipeline register between execute and memory. Loads, holds or inserts
 * a bubble according to the stall bits of the execute and memory stages.
 */
module ex_mem_reg (
    input  logic                 clk,
    input  logic                 arst_n,
    input  core_pkg::stall_t     stall_ctrl,
    input  core_pkg::pc_t        ex_pc,
    input  core_pkg::inst_type_t ex_inst_type,
    input  logic                 ex_rd_ena,
    input  core_pkg::xlen_t      ex_rd_data,
    input  core_pkg::reg_addr_t  ex_rd_addr,
    input  mem_pkg::ls_sel_t     ex_ls_sel,
    input  mem_pkg::data_addr_t  ex_ls_addr,
    output core_pkg::pc_t        mem_pc,
    output core_pkg::inst_type_t mem_inst_type,
    output logic                 mem_rd_ena,
    output core_pkg::xlen_t      mem_rd_data,
    output core_pkg::reg_addr_t  mem_rd_addr,
    output mem_pkg::ls_sel_t     mem_ls_sel,
    output mem_pkg::data_addr_t  mem_ls_addr
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_pc        <= '0;
            mem_inst_type <= core_pkg::inst_none;
            mem_rd_ena    <= 1'b0;
            mem_rd_data   <= '0;
            mem_rd_addr   <= '0;
            mem_ls_sel    <= '0;
            mem_ls_addr   <= '0;
        end else if (stall_ctrl[core_pkg::stall_mem]) begin
            // memory is busy with the current entry, keep it in place
        end else if (stall_ctrl[core_pkg::stall_ex]) begin
            // execute is stalled but memory moves on, so feed it a bubble
            mem_pc        <= '0;
            mem_inst_type <= core_pkg::inst_none;
            mem_rd_ena    <= 1'b0;
            mem_rd_data   <= '0;
            mem_rd_addr   <= '0;
            mem_ls_sel    <= '0;
            mem_ls_addr   <= '0;
        end else begin
            mem_pc        <= ex_pc;
            mem_inst_type <= ex_inst_type;
            mem_rd_ena    <= ex_rd_ena;
            mem_rd_data   <= ex_rd_data;
            mem_rd_addr   <= ex_rd_addr;
            mem_ls_sel    <= ex_ls_sel;
            mem_ls_addr   <= ex_ls_addr;
        end
    end

endmodule

// ==== source/mem_pkg.sv ====
/*
 * mem_pkg
 * Data-side memory types: APB widths, load/store access selector codes
 * and the geometry of the data RAM.
 */
package mem_pkg;

    localparam int apb_addr_bits = 32;
    localparam int apb_data_bits = 64;

    typedef logic [63:0]                  data_addr_t;
    typedef logic [apb_addr_bits-1:0]     apb_addr_t;
    typedef logic [apb_data_bits-1:0]     apb_data_t;
    typedef logic [apb_data_bits/8-1:0]   apb_strb_t;
    typedef logic [2:0]                   ls_sel_t;

    // codes 0 to 2 sign-extend, 4 to 6 zero-extend; stores look at the size only
    localparam ls_sel_t ls_byte   = 3'd0;
    localparam ls_sel_t ls_half   = 3'd1;
    localparam ls_sel_t ls_word   = 3'd2;
    localparam ls_sel_t ls_dword  = 3'd3;
    localparam ls_sel_t ls_byte_u = 3'd4;
    localparam ls_sel_t ls_half_u = 3'd5;
    localparam ls_sel_t ls_word_u = 3'd6;

    localparam int ram_depth_words = 256;
    localparam int ram_index_bits  = 8;

endpackage

// ==== source/core_pkg.sv ====
/*
 * core_pkg
 * Pipeline-wide types for the RV64 back end: data and PC widths, register
 * indices, instruction-type codes and the stall-vector bit positions.
 */
package core_pkg;

    localparam int xlen          = 64;
    localparam int reg_addr_bits = 5;
    localparam int stall_bits    = 5;

    typedef logic [xlen-1:0]          xlen_t;
    typedef logic [xlen-1:0]          pc_t;
    typedef logic [reg_addr_bits-1:0] reg_addr_t;
    typedef logic [7:0]               inst_type_t;
    typedef logic [stall_bits-1:0]    stall_t;

    // a PC of zero together with inst_none is a bubble
    localparam inst_type_t inst_none  = 8'd0;
    localparam inst_type_t inst_alu   = 8'd1;
    localparam inst_type_t inst_load  = 8'd2;
    localparam inst_type_t inst_store = 8'd3;

    // a set bit in the stall vector stalls that stage
    localparam int stall_pc  = 0;
    localparam int stall_if  = 1;
    localparam int stall_id  = 2;
    localparam int stall_ex  = 3;
    localparam int stall_mem = 4;

endpackage
